// File: common/panel_params.svh
// Timing values fit an 800x480 panel clocked at 25 MHz from clock_50 only.
// PWM and debounce counts are in clock_50 cycles.
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// Horizontal timing, in pixel ticks.
`define PANEL_H_ACTIVE 800
`define PANEL_H_FRONT 40
`define PANEL_H_SYNC 48
`define PANEL_H_BACK 40

// Vertical timing, in lines.
`define PANEL_V_ACTIVE 480
`define PANEL_V_FRONT 13
`define PANEL_V_SYNC 3
`define PANEL_V_BACK 29

// Overlay pixels are dark red, green and blue stay zero.
`define OVERLAY_RED 8'h80

// Backlight PWM, 50 MHz / 250 / 1000 gives 200 Hz.
`define PWM_MAX_VALUE 1000
`define PWM_BITS 10
`define PWM_PRESCALE 250

// Home key must be stable this long.
`define DEBOUNCE_CYCLES 1000

`endif

// File: common/panel_pkg.sv
// Types shared by the display blocks.
// Coordinates are 10 bits, enough for 928 ticks and 525 lines.
`include "panel_params.svh"

package panel_pkg;

    // Pixel position, including blanking.
    typedef logic [9:0] pos_x_t;
    typedef logic [9:0] pos_y_t;

    // One color channel.
    typedef logic [7:0] color_t;

    // Panel pixel, red in the top byte.
    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    // Backlight level, 0 to PWM_MAX_VALUE.
    typedef logic [`PWM_BITS-1:0] level_t;

endpackage

// File: common/pixel_bus_if.sv
`timescale 1ns/100ps
// Tick is a clock enable in the clock_50 domain, not a separate clock.
// Sync lines are active low.
interface pixel_bus_if;
    import panel_pkg::*;

    // High on every second clock_50.
    logic   tick;
    pos_x_t x;
    pos_y_t y;
    logic   data_enable;
    logic   hs_n;
    logic   vs_n;

    // Timing generator side.
    modport source (
        output tick,
        output x,
        output y,
        output data_enable,
        output hs_n,
        output vs_n
    );

    // Output stage side.
    modport sink (
        input tick,
        input data_enable,
        input hs_n,
        input vs_n
    );

endinterface

// File: hw/lcd_timing/lcd_timing.sv
`timescale 1ns/100ps
// Fixed 800x480 timing at half the clock_50 rate, no polarity options.
// Counters start at their last position so the first tick shows pixel (0,0).
`include "panel_params.svh"

module lcd_timing (
    input logic         clock_50,
    input logic         reset_n,
    pixel_bus_if.source bus
);
    import panel_pkg::*;

    localparam int H_TOTAL = `PANEL_H_ACTIVE + `PANEL_H_FRONT + `PANEL_H_SYNC + `PANEL_H_BACK;
    localparam int V_TOTAL = `PANEL_V_ACTIVE + `PANEL_V_FRONT + `PANEL_V_SYNC + `PANEL_V_BACK;
    localparam int H_SYNC_START = `PANEL_H_ACTIVE + `PANEL_H_FRONT;
    localparam int H_SYNC_END = H_SYNC_START + `PANEL_H_SYNC;
    localparam int V_SYNC_START = `PANEL_V_ACTIVE + `PANEL_V_FRONT;
    localparam int V_SYNC_END = V_SYNC_START + `PANEL_V_SYNC;

    logic   tick;
    pos_x_t h_count;
    pos_y_t v_count;
    logic   h_last;
    logic   v_last;

    // 25 MHz pixel tick.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    assign h_last = (h_count == pos_x_t'(H_TOTAL - 1));
    assign v_last = (v_count == pos_y_t'(V_TOTAL - 1));

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= pos_x_t'(H_TOTAL - 1);
            v_count <= pos_y_t'(V_TOTAL - 1);
        end else if (tick) begin
            if (h_last) begin
                h_count <= '0;
                // Next line, or back to the top.
                if (v_last) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    assign bus.tick = tick;
    assign bus.x = h_count;
    assign bus.y = v_count;

    // Visible area and sync pulses.
    assign bus.data_enable = (h_count < pos_x_t'(`PANEL_H_ACTIVE)) &&
                             (v_count < pos_y_t'(`PANEL_V_ACTIVE));
    assign bus.hs_n = !((h_count >= pos_x_t'(H_SYNC_START)) &&
                        (h_count < pos_x_t'(H_SYNC_END)));
    assign bus.vs_n = !((v_count >= pos_y_t'(V_SYNC_START)) &&
                        (v_count < pos_y_t'(V_SYNC_END)));

    // Counters must wrap before leaving the frame.
    x_in_frame: assert property (@(posedge clock_50) disable iff (!reset_n)
        h_count < pos_x_t'(H_TOTAL));
    y_in_frame: assert property (@(posedge clock_50) disable iff (!reset_n)
        v_count < pos_y_t'(V_TOTAL));

endmodule

// File: hw/lcd_output.sv
`timescale 1ns/100ps
// Color and overlay bit arrive one tick after their position is shown.
// Sync forcing acts on the bus sync lines without a register.
`include "panel_params.svh"

module lcd_output (
    input  logic             clock_50,
    input  logic             reset_n,
    pixel_bus_if.sink        bus,
    input  panel_pkg::rgb_t  pixel,
    input  logic             overlay_pixel,
    input  logic             overlay_enable,
    input  logic             hsync_off,
    input  logic             vsync_off,
    output panel_pkg::rgb_t  lcd_color,
    output logic             lcd_clock,
    output logic             lcd_de,
    output logic             lcd_hs_n,
    output logic             lcd_vs_n
);
    import panel_pkg::*;

    logic de_delayed;
    logic overlay_latched;
    rgb_t mixed_color;

    // Data enable follows the source's color by one tick.
    // The overlay bit comes with the color, so take it mid-period.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            de_delayed <= 1'b0;
            overlay_latched <= 1'b0;
        end else if (bus.tick) begin
            de_delayed <= bus.data_enable;
        end else begin
            overlay_latched <= overlay_pixel;
        end
    end

    always_comb begin
        if (overlay_latched && overlay_enable) begin
            mixed_color = rgb_t'{red: `OVERLAY_RED, green: 8'h00, blue: 8'h00};
        end else begin
            mixed_color = pixel;
        end
    end

    // Register every panel output.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            lcd_color <= '0;
            lcd_clock <= 1'b0;
            lcd_de <= 1'b0;
        end else begin
            lcd_color <= mixed_color;
            lcd_clock <= bus.tick;
            lcd_de <= de_delayed;
        end
    end

    assign lcd_hs_n = hsync_off ? 1'b1 : bus.hs_n;
    assign lcd_vs_n = vsync_off ? 1'b1 : bus.vs_n;

    // The panel samples on the rising lcd_clock, so lcd_de moves only while it is low.
    de_stable_at_clock: assert property (@(posedge clock_50) disable iff (!reset_n)
        $changed(lcd_de) |-> !lcd_clock);

endmodule

// File: hw/backlight/backlight_pwm.sv
`timescale 1ns/100ps
// Full brightness until the host marks its level valid.
// Levels of 0 and PWM_MAX_VALUE give a flat output.
`include "panel_params.svh"

module backlight_pwm (
    input  logic              clock_50,
    input  logic              reset_n,
    input  logic              brightness_valid,
    input  panel_pkg::level_t brightness,
    output logic              backlight
);
    import panel_pkg::*;

    localparam int PRESCALE_BITS = $clog2(`PWM_PRESCALE);

    logic [PRESCALE_BITS-1:0] prescale_count;
    logic                     pwm_step;
    level_t                   duty_count;
    level_t                   level;

    // One step every PWM_PRESCALE clocks.
    assign pwm_step = (prescale_count == PRESCALE_BITS'(`PWM_PRESCALE - 1));

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            prescale_count <= '0;
        end else if (pwm_step) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 1'b1;
        end
    end

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            duty_count <= '0;
        end else if (pwm_step) begin
            if (duty_count == level_t'(`PWM_MAX_VALUE - 1)) begin
                duty_count <= '0;
            end else begin
                duty_count <= duty_count + 1'b1;
            end
        end
    end

    // Clamp the host value, default to full on.
    always_comb begin
        if (!brightness_valid || brightness > level_t'(`PWM_MAX_VALUE)) begin
            level = level_t'(`PWM_MAX_VALUE);
        end else begin
            level = brightness;
        end
    end

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            backlight <= 1'b0;
        end else begin
            backlight <= (duty_count < level);
        end
    end

    duty_in_range: assert property (@(posedge clock_50) disable iff (!reset_n)
        duty_count < level_t'(`PWM_MAX_VALUE));

endmodule

// File: hw/home_button.sv
`timescale 1ns/100ps
// Key is active low and asynchronous to clock_50.
// The host sees a new level only after acknowledging the last one.
`include "panel_params.svh"

module home_button (
    input  logic clock_50,
    input  logic reset_n,
    input  logic home_key_n,
    input  logic home_ack,
    output logic home_pressed
);
    localparam int COUNT_BITS = $clog2(`DEBOUNCE_CYCLES);

    logic                  key_meta;
    logic                  key_sync;
    logic                  key_down;
    logic                  debounced;
    logic [COUNT_BITS-1:0] stable_count;

    // Two-flop synchronizer, idle level is high.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
        end else begin
            key_meta <= home_key_n;
            key_sync <= key_meta;
        end
    end

    assign key_down = !key_sync;

    // Count samples that disagree with the debounced level.
    // Any agreeing sample starts the count again.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            stable_count <= '0;
            debounced <= 1'b0;
        end else if (key_down == debounced) begin
            stable_count <= '0;
        end else if (stable_count == COUNT_BITS'(`DEBOUNCE_CYCLES - 1)) begin
            stable_count <= '0;
            debounced <= key_down;
        end else begin
            stable_count <= stable_count + 1'b1;
        end
    end

    // Hold the report until the host echoes it.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            home_pressed <= 1'b0;
        end else if (home_pressed == home_ack) begin
            home_pressed <= debounced;
        end
    end

endmodule

// File: hw/lcd_panel_top.sv
`timescale 1ns/100ps
// Display side of the board, all in the clock_50 domain.
// Pixel data must follow the position by one tick, see lcd_output.

module lcd_panel_top (
    input  logic       clock_50,
    input  logic       reset_n,
    input  logic [7:0] pixel_red,
    input  logic [7:0] pixel_green,
    input  logic [7:0] pixel_blue,
    input  logic       overlay_pixel,
    input  logic       overlay_enable,
    input  logic       hsync_off,
    input  logic       vsync_off,
    input  logic       brightness_valid,
    input  logic [9:0] brightness,
    input  logic       home_key_n,
    input  logic       home_ack,
    output logic [9:0] pixel_x,
    output logic [9:0] pixel_y,
    output logic [7:0] lcd_red,
    output logic [7:0] lcd_green,
    output logic [7:0] lcd_blue,
    output logic       lcd_clock,
    output logic       lcd_de,
    output logic       lcd_hs_n,
    output logic       lcd_vs_n,
    output logic       lcd_backlight,
    output logic       home_pressed
);

    pixel_bus_if bus ();

    lcd_timing u_lcd_timing (
        .clock_50 (clock_50),
        .reset_n  (reset_n),
        .bus      (bus.source)
    );

    // Position goes out to the pixel source.
    assign pixel_x = bus.x;
    assign pixel_y = bus.y;

    // Color channels pack into the struct in red, green, blue order.
    lcd_output u_lcd_output (
        .clock_50       (clock_50),
        .reset_n        (reset_n),
        .bus            (bus.sink),
        .pixel          ({pixel_red, pixel_green, pixel_blue}),
        .overlay_pixel  (overlay_pixel),
        .overlay_enable (overlay_enable),
        .hsync_off      (hsync_off),
        .vsync_off      (vsync_off),
        .lcd_color      ({lcd_red, lcd_green, lcd_blue}),
        .lcd_clock      (lcd_clock),
        .lcd_de         (lcd_de),
        .lcd_hs_n       (lcd_hs_n),
        .lcd_vs_n       (lcd_vs_n)
    );

    backlight_pwm u_backlight_pwm (
        .clock_50         (clock_50),
        .reset_n          (reset_n),
        .brightness_valid (brightness_valid),
        .brightness       (brightness),
        .backlight        (lcd_backlight)
    );

    home_button u_home_button (
        .clock_50     (clock_50),
        .reset_n      (reset_n),
        .home_key_n   (home_key_n),
        .home_ack     (home_ack),
        .home_pressed (home_pressed)
    );

endmodule

// File: bench/tb_lcd_panel.sv
`timescale 1ns/100ps
// Pixel source follows the one-tick data delay; backlight and home key run beside the video.
// A cycle counter bounds the run.
`include "panel_params.svh"

module tb_lcd_panel;

    localparam int H_TOTAL = `PANEL_H_ACTIVE + `PANEL_H_FRONT + `PANEL_H_SYNC + `PANEL_H_BACK;
    localparam int V_TOTAL = `PANEL_V_ACTIVE + `PANEL_V_FRONT + `PANEL_V_SYNC + `PANEL_V_BACK;
    localparam int FRAME_CLOCKS = 2 * H_TOTAL * V_TOTAL;
    localparam int ACTIVE_PIXELS = `PANEL_H_ACTIVE * `PANEL_V_ACTIVE;
    localparam int HS_LOW_CLOCKS = 2 * `PANEL_H_SYNC;
    localparam int VS_LOW_CLOCKS = 2 * H_TOTAL * `PANEL_V_SYNC;
    localparam int PWM_WINDOW = `PWM_PRESCALE * `PWM_MAX_VALUE;
    // Startup and four frames of video, plus one frame of margin.
    localparam int CYCLE_LIMIT = 6 * FRAME_CLOCKS;

    logic       clock_50 = 1'b0;
    logic       reset_n = 1'b0;
    logic [7:0] pixel_red = '0;
    logic [7:0] pixel_green = '0;
    logic [7:0] pixel_blue = '0;
    logic       overlay_pixel = 1'b0;
    logic       overlay_enable = 1'b0;
    logic       hsync_off = 1'b0;
    logic       vsync_off = 1'b0;
    logic       brightness_valid = 1'b0;
    logic [9:0] brightness = '0;
    logic       home_key_n = 1'b1;
    logic       home_ack = 1'b0;
    logic [9:0] pixel_x;
    logic [9:0] pixel_y;
    logic [7:0] lcd_red;
    logic [7:0] lcd_green;
    logic [7:0] lcd_blue;
    logic       lcd_clock;
    logic       lcd_de;
    logic       lcd_hs_n;
    logic       lcd_vs_n;
    logic       lcd_backlight;
    logic       home_pressed;

    integer     seed;
    int         levels [2];
    int         bounces [5];
    int         cycle_count = 0;
    logic [9:0] pos_x_d = '0;
    logic [9:0] pos_y_d = '0;

    // Monitor state.
    logic        last_hs = 1'b1;
    logic        last_vs = 1'b1;
    bit          hs_fall_seen = 1'b0;
    bit          vs_fall_seen = 1'b0;
    int          hs_fall_at;
    int          vs_fall_at;
    int          pixel_index = 0;
    int          active_in_frame = 0;
    logic [23:0] expected_rgb;

    lcd_panel_top u_dut (.*);

    initial begin
        forever #20 clock_50 = ~clock_50;
    end

    function automatic logic [23:0] ref_color(input int x, input int y);
        logic [7:0] r;
        logic [7:0] g;
        r = x[7:0];
        g = y[7:0];
        return {r, g, r ^ g};
    endfunction

    function automatic bit ref_overlay(input int x, input int y);
        return (x % 8 == 0) && (y % 8 == 0);
    endfunction

    function automatic int expected_high_cycles(input bit valid, input int level);
        int eff;
        if (!valid || level > `PWM_MAX_VALUE) begin
            eff = `PWM_MAX_VALUE;
        end else begin
            eff = level;
        end
        return eff * `PWM_PRESCALE;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] time %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        $display("Errors found");
        $fatal(1, "check failed");
    endtask

    // Source presents data for a position one tick after it was shown.
    always @(posedge clock_50) begin
        pos_x_d <= pixel_x;
        pos_y_d <= pixel_y;
        {pixel_red, pixel_green, pixel_blue} <= ref_color(int'(pos_x_d), int'(pos_y_d));
        overlay_pixel <= ref_overlay(int'(pos_x_d), int'(pos_y_d));
    end

    always @(posedge clock_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped: no result after %0d clock cycles", CYCLE_LIMIT);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // Compares pixels and sync timing against the reference.
    always @(posedge clock_50) begin
        if (reset_n) begin
            if (lcd_clock && lcd_de) begin
                if (overlay_enable && ref_overlay(pixel_index % `PANEL_H_ACTIVE,
                                                  pixel_index / `PANEL_H_ACTIVE)) begin
                    expected_rgb = {`OVERLAY_RED, 8'h00, 8'h00};
                end else begin
                    expected_rgb = ref_color(pixel_index % `PANEL_H_ACTIVE,
                                             pixel_index / `PANEL_H_ACTIVE);
                end
                assert ({lcd_red, lcd_green, lcd_blue} == expected_rgb)
                    else report_mismatch("lcd_rgb", int'(expected_rgb),
                                         int'({lcd_red, lcd_green, lcd_blue}));
                pixel_index = (pixel_index + 1 == ACTIVE_PIXELS) ? 0 : pixel_index + 1;
                active_in_frame++;
            end
            if (last_hs && !lcd_hs_n) begin
                hs_fall_at = cycle_count;
                hs_fall_seen = 1'b1;
            end
            if (!last_hs && lcd_hs_n && hs_fall_seen) begin
                assert (cycle_count - hs_fall_at == HS_LOW_CLOCKS)
                    else report_mismatch("lcd_hs_n low clocks", HS_LOW_CLOCKS,
                                         cycle_count - hs_fall_at);
            end
            if (last_vs && !lcd_vs_n) begin
                if (vs_fall_seen) begin
                    assert (cycle_count - vs_fall_at == FRAME_CLOCKS)
                        else report_mismatch("lcd_vs_n period", FRAME_CLOCKS,
                                             cycle_count - vs_fall_at);
                    assert (active_in_frame == ACTIVE_PIXELS)
                        else report_mismatch("lcd_de pixels", ACTIVE_PIXELS, active_in_frame);
                end
                vs_fall_at = cycle_count;
                vs_fall_seen = 1'b1;
                active_in_frame = 0;
            end
            if (!last_vs && lcd_vs_n && vs_fall_seen) begin
                assert (cycle_count - vs_fall_at == VS_LOW_CLOCKS)
                    else report_mismatch("lcd_vs_n low clocks", VS_LOW_CLOCKS,
                                         cycle_count - vs_fall_at);
            end
            // Forced sync breaks the frame period.
            if (vsync_off) begin
                vs_fall_seen = 1'b0;
            end
            last_hs = lcd_hs_n;
            last_vs = lcd_vs_n;
        end
    end

    task automatic wait_vs_edge(input bit rising);
        logic last;
        bit   done;
        last = lcd_vs_n;
        done = 1'b0;
        while (!done) begin
            @(posedge clock_50);
            done = rising ? (!last && lcd_vs_n) : (last && !lcd_vs_n);
            last = lcd_vs_n;
        end
    endtask

    // One frame with a single sync line forced high, the other keeps running.
    task automatic forced_sync_frame(input bit force_hs);
        int other_low;
        other_low = 0;
        hsync_off <= force_hs;
        vsync_off <= !force_hs;
        repeat (FRAME_CLOCKS) begin
            @(posedge clock_50);
            if (force_hs) begin
                assert (lcd_hs_n == 1'b1) else report_mismatch("lcd_hs_n", 1, int'(lcd_hs_n));
                if (!lcd_vs_n) begin
                    other_low++;
                end
            end else begin
                assert (lcd_vs_n == 1'b1) else report_mismatch("lcd_vs_n", 1, int'(lcd_vs_n));
                if (!lcd_hs_n) begin
                    other_low++;
                end
            end
        end
        if (force_hs) begin
            assert (other_low == VS_LOW_CLOCKS)
                else report_mismatch("lcd_vs_n low clocks", VS_LOW_CLOCKS, other_low);
        end else begin
            assert (other_low == HS_LOW_CLOCKS * V_TOTAL)
                else report_mismatch("lcd_hs_n low clocks", HS_LOW_CLOCKS * V_TOTAL,
                                     other_low);
        end
    endtask

    task automatic video_tests();
        wait_vs_edge(1'b0);
        wait_vs_edge(1'b0);
        overlay_enable <= 1'b1;
        wait_vs_edge(1'b0);
        overlay_enable <= 1'b0;
        wait_vs_edge(1'b1);
        forced_sync_frame(1'b1);
        forced_sync_frame(1'b0);
        hsync_off <= 1'b0;
        vsync_off <= 1'b0;
    endtask

    task automatic backlight_case(input bit valid, input int level);
        int on_count;
        brightness_valid <= valid;
        brightness <= 10'(level);
        repeat (PWM_WINDOW) @(posedge clock_50);
        on_count = 0;
        repeat (PWM_WINDOW) begin
            @(posedge clock_50);
            if (lcd_backlight) begin
                on_count++;
            end
        end
        assert (on_count == expected_high_cycles(valid, level))
            else report_mismatch("lcd_backlight high cycles",
                                 expected_high_cycles(valid, level), on_count);
    endtask

    task automatic backlight_tests();
        backlight_case(1'b0, 0);
        backlight_case(1'b1, 0);
        backlight_case(1'b1, `PWM_MAX_VALUE);
        backlight_case(1'b1, levels[0]);
        backlight_case(1'b1, levels[1]);
    endtask

    task automatic wait_pressed(input logic level);
        int waited;
        waited = 0;
        while (home_pressed != level) begin
            @(posedge clock_50);
            waited++;
            assert (waited <= `DEBOUNCE_CYCLES + 10)
                else report_mismatch("home_pressed", int'(level), int'(home_pressed));
        end
    endtask

    task automatic hold_and_check(input int cycles, input logic level);
        repeat (cycles) begin
            @(posedge clock_50);
            assert (home_pressed == level)
                else report_mismatch("home_pressed", int'(level), int'(home_pressed));
        end
    endtask

    task automatic home_key_tests();
        // Short bounces, each followed by a quiet gap.
        foreach (bounces[i]) begin
            home_key_n <= 1'b0;
            hold_and_check(bounces[i], 1'b0);
            home_key_n <= 1'b1;
            hold_and_check(50, 1'b0);
        end
        home_key_n <= 1'b0;
        wait_pressed(1'b1);
        home_key_n <= 1'b1;
        hold_and_check(3 * `DEBOUNCE_CYCLES, 1'b1);
        home_ack <= 1'b1;
        wait_pressed(1'b0);
        home_ack <= 1'b0;
    endtask

    initial begin
        seed = 32'h312a;
        foreach (levels[i]) begin
            levels[i] = {$random(seed)} % `PWM_MAX_VALUE;
        end
        foreach (bounces[i]) begin
            bounces[i] = 1 + {$random(seed)} % (`DEBOUNCE_CYCLES - 100);
        end
        repeat (4) @(posedge clock_50);
        reset_n <= 1'b1;
        fork
            video_tests();
            backlight_tests();
            home_key_tests();
        join
        $display("No errors");
        $finish;
    end

endmodule

// File: lcd_panel.f
+incdir+common
common/panel_pkg.sv
common/pixel_bus_if.sv
hw/lcd_timing/lcd_timing.sv
hw/lcd_output.sv
hw/backlight/backlight_pwm.sv
hw/home_button.sv
hw/lcd_panel_top.sv
bench/tb_lcd_panel.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f lcd_panel.f \
    --top-module tb_lcd_panel \
    -Mdir obj_dir

output=$(./obj_dir/Vtb_lcd_panel) || true
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
